// File: verilog/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// one machine word, also the address width
`define RV_XLEN 32

`define RV_REG_AW 5    // 32 architectural registers

// first fetch after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: verilog/rv_pkg.sv
`default_nettype none
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] regIdx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASSB,  // lui
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE
    } aluOp_t;

    typedef enum logic [1:0] {FETCH, EXEC, DATA} reqState_t;

endpackage

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module registerFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            regWrite,
    input  rv_pkg::regIdx_t reg1,
    input  rv_pkg::regIdx_t reg2,
    input  rv_pkg::regIdx_t regD,
    input  rv_pkg::word_t   writeData,
    output rv_pkg::word_t   readData1,
    output rv_pkg::word_t   readData2
);
    import rv_pkg::*;

    localparam int NumRegs = 1 << `RV_REG_AW;

    word_t regs [0:NumRegs-1];

    // x0 is never written, so it reads back as zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && regD != '0) begin
            regs[regD] <= writeData;
        end
    end

    assign readData1 = regs[reg1];
    assign readData2 = regs[reg2];

endmodule

`default_nettype wire

// File: verilog/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  rv_pkg::word_t   instr,
    input  logic            branchFlag,
    input  logic            freeze,
    output rv_pkg::regIdx_t reg1,
    output rv_pkg::regIdx_t reg2,
    output rv_pkg::regIdx_t regD,
    output rv_pkg::word_t   imm,
    output rv_pkg::aluOp_t  aluOp,
    output logic            aluSrc,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            memToReg,
    output logic            branchTaken,
    output logic            jal,
    output logic            jalr
);
    import rv_pkg::*;

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic        writesReg;  // before the commit qualifier
    logic        isBranch;
    aluOp_t      arithOp;
    word_t       immI;
    word_t       immS;
    word_t       immB;
    word_t       immU;
    word_t       immJ;

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign reg1 = instr[19:15];
    assign reg2 = instr[24:20];
    assign regD = instr[11:7];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared by OP and OP_IMM, sub only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == OP && funct7b5) ? ALU_SUB : ALU_ADD;
            3'b001:  arithOp = ALU_SLL;
            3'b010:  arithOp = ALU_SLT;
            3'b011:  arithOp = ALU_SLTU;
            3'b100:  arithOp = ALU_XOR;
            3'b101:  arithOp = funct7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
    end

    always_comb begin
        imm       = immI;
        aluOp     = ALU_ADD;
        aluSrc    = 1'b0;
        writesReg = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        isBranch  = 1'b0;
        jal       = 1'b0;
        jalr      = 1'b0;
        case (opcode)
            OP: begin
                aluOp     = arithOp;
                writesReg = 1'b1;
            end
            OP_IMM: begin
                aluOp     = arithOp;
                aluSrc    = 1'b1;
                writesReg = 1'b1;
            end
            LUI: begin
                imm       = immU;
                aluOp     = ALU_PASSB;
                aluSrc    = 1'b1;
                writesReg = 1'b1;
            end
            LOAD: begin
                aluSrc    = 1'b1;
                writesReg = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
            end
            STORE: begin
                imm      = immS;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            BRANCH: begin
                imm      = immB;
                isBranch = 1'b1;
                case (funct3)
                    3'b000:  aluOp = ALU_BEQ;
                    3'b001:  aluOp = ALU_BNE;
                    3'b100:  aluOp = ALU_BLT;
                    3'b101:  aluOp = ALU_BGE;
                    default: aluOp = ALU_ADD;  // unsupported, flag stays low
                endcase
            end
            JAL: begin
                imm       = immJ;
                jal       = 1'b1;
                writesReg = 1'b1;
            end
            JALR: begin
                aluSrc    = 1'b1;  // rs1 + imm is the target
                jalr      = 1'b1;
                writesReg = 1'b1;
            end
            default: ;  // anything else retires as a nop
        endcase
    end

    assign regWrite    = writesReg & ~freeze;
    assign branchTaken = isBranch & branchFlag;

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  rv_pkg::word_t  srcA,
    input  rv_pkg::word_t  srcB,
    input  rv_pkg::aluOp_t aluOp,
    output rv_pkg::word_t  result,
    output logic           branchFlag
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       signedLt;
    logic       unsignedLt;
    logic       equal;

    assign shamt      = srcB[4:0];
    assign signedLt   = $signed(srcA) < $signed(srcB);
    assign unsignedLt = srcA < srcB;
    assign equal      = srcA == srcB;

    always_comb begin
        result     = '0;
        branchFlag = 1'b0;
        case (aluOp)
            ALU_ADD:   result = srcA + srcB;
            ALU_SUB:   result = srcA - srcB;
            ALU_AND:   result = srcA & srcB;
            ALU_OR:    result = srcA | srcB;
            ALU_XOR:   result = srcA ^ srcB;
            ALU_SLT:   result = word_t'(signedLt);
            ALU_SLTU:  result = word_t'(unsignedLt);
            ALU_SLL:   result = srcA << shamt;
            ALU_SRL:   result = srcA >> shamt;
            ALU_SRA:   result = $signed(srcA) >>> shamt;
            ALU_PASSB: result = srcB;
            // compare modes only raise the flag
            ALU_BEQ:   branchFlag = equal;
            ALU_BNE:   branchFlag = ~equal;
            ALU_BLT:   branchFlag = signedLt;
            ALU_BGE:   branchFlag = ~signedLt;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/programCounter.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module programCounter (
    input  logic          clk,
    input  logic          rstN,
    input  logic          freeze,
    input  logic          branchTaken,
    input  logic          jal,
    input  logic          jalr,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t jalrTarget,
    output rv_pkg::word_t pc
);
    import rv_pkg::*;

    word_t nextPc;

    always_comb begin
        if (jalr) begin
            nextPc = jalrTarget & ~word_t'(1);  // bit 0 dropped per spec
        end else if (branchTaken || jal) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + word_t'(4);
        end
    end

    // only moves in the commit cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else if (!freeze) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/requestUnit.sv
`timescale 1ns/10ps
`default_nettype none

module requestUnit (
    input  logic          clk,
    input  logic          rstN,
    input  logic          iAck,
    input  logic          dAck,
    input  rv_pkg::word_t instruction,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t memAddress,
    input  logic          memRead,
    input  logic          memWrite,
    output rv_pkg::word_t finalAddress,
    output rv_pkg::word_t instrOut,
    output logic          iRead,
    output logic          dRead,
    output logic          dWrite,
    output logic          freeze
);
    import rv_pkg::*;

    reqState_t state;
    reqState_t nextState;
    logic      memAccess;

    assign memAccess = memRead | memWrite;

    always_comb begin
        nextState = state;
        case (state)
            FETCH: begin
                if (iAck) begin
                    nextState = EXEC;
                end
            end
            EXEC:    nextState = memAccess ? DATA : FETCH;
            DATA: begin
                if (dAck) begin
                    nextState = FETCH;
                end
            end
            default: nextState = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    // instruction held for the rest of its execution
    always_ff @(posedge clk) begin
        if (state == FETCH && iAck) begin
            instrOut <= instruction;
        end
    end

    assign iRead        = (state == FETCH);
    assign dRead        = (state == DATA) & memRead;
    assign dWrite       = (state == DATA) & memWrite;
    assign finalAddress = (state == FETCH) ? pc : memAddress;

    // low for exactly one cycle per instruction
    always_comb begin
        case (state)
            EXEC:    freeze = memAccess;
            DATA:    freeze = ~dAck;  // load data lands with the ack
            default: freeze = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  logic          clk,
    input  logic          rstN,
    input  logic          iAck,
    input  logic          dAck,
    input  rv_pkg::word_t instruction,
    input  rv_pkg::word_t memLoad,
    output rv_pkg::word_t finalAddress,
    output rv_pkg::word_t memStore,
    output logic          iRead,
    output logic          dRead,
    output logic          dWrite
);
    import rv_pkg::*;

    regIdx_t reg1;
    regIdx_t reg2;
    regIdx_t regD;
    word_t   imm;
    aluOp_t  aluOp;
    logic    aluSrc;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    memToReg;
    logic    branchTaken;
    logic    jal;
    logic    jalr;
    logic    branchFlag;
    logic    freeze;
    word_t   pc;
    word_t   pcPlus4;
    word_t   readData1;
    word_t   readData2;
    word_t   aluInputB;
    word_t   aluResult;
    word_t   writeBack;
    word_t   instrOut;

    assign pcPlus4 = pc + word_t'(4);

    registerFile rf (
        .clk(clk),
        .rstN(rstN),
        .regWrite(regWrite),
        .reg1(reg1),
        .reg2(reg2),
        .regD(regD),
        .writeData(writeBack),
        .readData1(readData1),
        .readData2(readData2)
    );

    controlUnit cu (
        .instr(instrOut),
        .branchFlag(branchFlag),
        .freeze(freeze),
        .reg1(reg1),
        .reg2(reg2),
        .regD(regD),
        .imm(imm),
        .aluOp(aluOp),
        .aluSrc(aluSrc),
        .regWrite(regWrite),
        .memRead(memRead),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .branchTaken(branchTaken),
        .jal(jal),
        .jalr(jalr)
    );

    assign aluInputB = aluSrc ? imm : readData2;

    alu aluUnit (
        .srcA(readData1),
        .srcB(aluInputB),
        .aluOp(aluOp),
        .result(aluResult),
        .branchFlag(branchFlag)
    );

    // link address wins over the alu for jumps
    assign writeBack = memToReg    ? memLoad :
                       (jal | jalr) ? pcPlus4 : aluResult;

    programCounter pcReg (
        .clk(clk),
        .rstN(rstN),
        .freeze(freeze),
        .branchTaken(branchTaken),
        .jal(jal),
        .jalr(jalr),
        .imm(imm),
        .jalrTarget(aluResult),
        .pc(pc)
    );

    requestUnit ru (
        .clk(clk),
        .rstN(rstN),
        .iAck(iAck),
        .dAck(dAck),
        .instruction(instruction),
        .pc(pc),
        .memAddress(aluResult),
        .memRead(memRead),
        .memWrite(memWrite),
        .finalAddress(finalAddress),
        .instrOut(instrOut),
        .iRead(iRead),
        .dRead(dRead),
        .dWrite(dWrite),
        .freeze(freeze)
    );

    assign memStore = readData2;  // rs2 straight out for sw

endmodule

`default_nettype wire

// File: testbench/datapath_assert.sv
`timescale 1ns/10ps
`default_nettype none

module datapath_assert (
    input logic              clk,
    input logic              rstN,
    input logic              iAck,
    input logic              dAck,
    input logic              iRead,
    input logic              dRead,
    input logic              dWrite,
    input rv_pkg::word_t     finalAddress,
    input rv_pkg::reqState_t state
);
    import rv_pkg::*;

    oneStrobe: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({iRead, dRead, dWrite}))
        else $error("more than one bus strobe high");

    // a waiting request keeps its address
    addrStable: assert property (@(posedge clk) disable iff (!rstN)
        ((iRead && !iAck) || ((dRead || dWrite) && !dAck))
        |=> (finalAddress == $past(finalAddress)))
        else $error("address changed while a request waited");

    resetStrobes: assert property (@(posedge clk)
        !rstN |-> (state == FETCH && iRead && !dRead && !dWrite))
        else $error("wrong strobes during reset");

endmodule

bind requestUnit datapath_assert assertInst (
    .clk(clk),
    .rstN(rstN),
    .iAck(iAck),
    .dAck(dAck),
    .iRead(iRead),
    .dRead(dRead),
    .dWrite(dWrite),
    .finalAddress(finalAddress),
    .state(state)
);

`default_nettype wire

// File: testbench/datapath_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module datapath_tb;
    import rv_pkg::*;

    localparam int maxRecords = 100;
    localparam int memWords = 256;     // 0x000 to 0x3ff
    localparam int ackTimeout = 20;
    localparam int runTimeout = 5000;

    logic  clk;
    logic  rstN;
    logic  iAck;
    logic  dAck;
    word_t instruction;
    word_t memLoad;
    word_t finalAddress;
    word_t memStore;
    logic  iRead;
    logic  dRead;
    logic  dWrite;

    word_t       patterns [0:3*maxRecords-1];
    word_t       mem [0:memWords-1];
    word_t       expAddr [$];
    word_t       expData [$];
    word_t       haltAddr;
    logic [31:0] lcgState;
    int          cycles;
    logic        halted;

    datapath datapath_inst (
        .clk(clk),
        .rstN(rstN),
        .iAck(iAck),
        .dAck(dAck),
        .instruction(instruction),
        .memLoad(memLoad),
        .finalAddress(finalAddress),
        .memStore(memStore),
        .iRead(iRead),
        .dRead(dRead),
        .dWrite(dWrite)
    );

    always #50 clk = ~clk;

    // untouched words read back as a function of their address
    function automatic word_t fillWord(input word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hA5A5_0000 ^ addr;
    endfunction

    function automatic logic [1:0] nextDelay();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:30];  // 0 to 3 cycles
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
        cycles++;
        assert (cycles < runTimeout)
            else reportFailure("timeout: the halt address was never fetched");
    endtask

    // each record holds type, address and data
    task automatic loadPatterns();
        word_t kind;
        word_t addr;
        for (int i = 0; i < memWords; i++) begin
            mem[i] = fillWord(word_t'(i * 4));
        end
        for (int i = 0; i < 3 * maxRecords; i++) begin
            patterns[i] = '0;
        end
        $readmemh("testbench/datapath_patterns.txt", patterns);
        haltAddr = '1;
        for (int r = 0; r < maxRecords; r++) begin
            kind = patterns[3*r];
            addr = patterns[3*r+1];
            case (kind)
                1, 2: mem[addr[9:2]] = patterns[3*r+2];  // program or data word
                3: begin
                    expAddr.push_back(addr);
                    expData.push_back(patterns[3*r+2]);
                end
                4: haltAddr = addr;
                default: ;
            endcase
        end
        assert (haltAddr != '1 && expAddr.size() > 0)
            else reportFailure("pattern file has no halt address or no stores");
    endtask

    task automatic waitRequest();
        int waited;
        waited = 0;
        while (!(iRead || dRead || dWrite)) begin
            stepCycle();
            waited++;
            assert (waited < ackTimeout)
                else reportFailure("timeout: no bus request after the last acknowledge");
        end
    endtask

    task automatic serveRequest();
        word_t      addr;
        logic [1:0] delay;
        logic       isFetch;
        logic       isLoad;
        addr    = finalAddress;
        isFetch = iRead;
        isLoad  = dRead;
        assert (addr < word_t'(memWords * 4))
            else reportFailure($sformatf("[ERROR] %0t: address %h outside memory", $time, addr));
        if (dWrite) begin
            assert (expAddr.size() > 0)
                else reportFailure($sformatf("[ERROR] %0t: extra store to %h data %h",
                                             $time, addr, memStore));
            assert (addr == expAddr[0] && memStore == expData[0])
                else reportFailure($sformatf("[ERROR] %0t: store %h=%h, expected %h=%h",
                                             $time, addr, memStore, expAddr[0], expData[0]));
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            mem[addr[9:2]] = memStore;
        end
        delay = nextDelay();
        repeat (delay) stepCycle();
        if (isFetch) begin
            instruction = mem[addr[9:2]];
            iAck = 1'b1;
        end else begin
            if (isLoad) begin
                memLoad = mem[addr[9:2]];
            end
            dAck = 1'b1;
        end
        stepCycle();
        iAck = 1'b0;
        dAck = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        iAck        = 1'b0;
        dAck        = 1'b0;
        instruction = '0;
        memLoad     = '0;
        lcgState    = 32'd81802;
        cycles      = 0;
        halted      = 1'b0;
        loadPatterns();
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        waitRequest();
        assert (iRead && !dRead && !dWrite && finalAddress == `RV_RESET_PC)
            else reportFailure($sformatf("[ERROR] %0t: first request is not a fetch of %h",
                                         $time, `RV_RESET_PC));
        while (!halted) begin
            waitRequest();
            if (iRead && finalAddress == haltAddr) begin
                halted = 1'b1;
            end else begin
                serveRequest();
            end
        end
        if (expAddr.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            reportFailure($sformatf("[ERROR] %0t: halt reached with %0d stores missing",
                                    $time, expAddr.size()));
        end
    end

endmodule

`default_nettype wire

// File: testbench/datapath_patterns.txt
// columns: type address data, all hex
// type 1 program word, 2 initial data word, 3 expected store in order, 4 halt address
1 00000000 00500093
1 00000004 FFD00113
1 00000008 002081B3
1 0000000C 40208233
1 00000010 001122B3
1 00000014 00113333
1 00000018 401153B3
1 0000001C 00115433
1 00000020 001094B3
1 00000024 0020C533
1 00000028 0020E5B3
1 0000002C 0020F633
1 00000030 0F017693
1 00000034 00409713
1 00000038 40115793
1 0000003C 12345837
1 00000040 20002883
1 00000044 10000A13
1 00000048 003A2023
1 0000004C 004A2223
1 00000050 005A2423
1 00000054 006A2623
1 00000058 007A2823
1 0000005C 008A2A23
1 00000060 009A2C23
1 00000064 00AA2E23
1 00000068 02BA2023
1 0000006C 02CA2223
1 00000070 02DA2423
1 00000074 02EA2623
1 00000078 02FA2823
1 0000007C 030A2A23
1 00000080 031A2C23
1 00000084 00108463
1 00000088 022A2E23
1 0000008C 00109463
1 00000090 041A2023
1 00000094 00114463
1 00000098 022A2E23
1 0000009C 00115463
1 000000A0 042A2223
1 000000A4 00209463
1 000000A8 022A2E23
1 000000AC 0020D463
1 000000B0 022A2E23
1 000000B4 00208663
1 000000B8 0020C463
1 000000BC 00800B6F
1 000000C0 022A2E23
1 000000C4 056A2423
1 000000C8 0D900B93
1 000000CC 000B8C67
1 000000D0 022A2E23
1 000000D4 022A2E23
1 000000D8 058A2623
1 000000DC 0000006F
2 00000200 CAFEBABE
3 00000100 00000002
3 00000104 00000008
3 00000108 00000001
3 0000010C 00000000
3 00000110 FFFFFFFF
3 00000114 07FFFFFF
3 00000118 000000A0
3 0000011C FFFFFFF8
3 00000120 FFFFFFFD
3 00000124 00000005
3 00000128 000000F0
3 0000012C 00000050
3 00000130 FFFFFFFE
3 00000134 12345000
3 00000138 CAFEBABE
3 00000140 00000005
3 00000144 FFFFFFFD
3 00000148 000000C0
3 0000014C 000000D0
4 000000DC 00000000

// File: list.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/registerFile.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/programCounter.sv
verilog/requestUnit.sv
verilog/datapath.sv
testbench/datapath_assert.sv
testbench/datapath_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module datapath_tb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
exit 0
